/* logic/print_pkg.sv */
// shared widths, constants and types for the number printing subsystem; import with print_pkg::*.

package print_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sizes and encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int VALUE_W    = 30;
	localparam int DIGITS     = 10;
	localparam int CHAR_W     = 6;
	localparam int LINE_DEPTH = 16;
	localparam int ADDR_W     = $clog2(LINE_DEPTH);

	// the step counter has to hold DIGITS, which marks a finished word.
	localparam int STEP_W = $clog2(DIGITS + 1);

	// nine times the largest power of ten needs four bits more than a value.
	localparam int MULT_W = VALUE_W + 4;

	// one octal digit covers three bits of the value.
	localparam int OCT_BITS = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [VALUE_W-1:0] value_t;
	typedef logic [CHAR_W-1:0]  char_t;
	typedef logic [ADDR_W-1:0]  line_addr_t;

	// slot DIGITS-1 holds the most significant digit.
	typedef char_t [DIGITS-1:0] char_word_t;

	typedef struct packed {
		line_addr_t addr;
		char_word_t word;
	} line_wr_t;

	// digit d prints as code 30 + d.
	localparam char_t CHAR_ZERO = char_t'(30);

	// powers of ten, the highest in slot DIGITS-1.
	localparam logic [DIGITS-1:0][VALUE_W-1:0] POW10 = {
		30'd1000000000,
		30'd100000000,
		30'd10000000,
		30'd1000000,
		30'd100000,
		30'd10000,
		30'd1000,
		30'd100,
		30'd10,
		30'd1
	};

endpackage

/* logic/dec_char_conv.sv */
// decimal conversion unit; a start pulse turns a binary value into ten digit codes and a buffer write.
`timescale 1ns/100ps

module dec_char_conv import print_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  value_t     value,
	input  line_addr_t addr,
	input  logic       gnt,
	output logic       busy,
	output logic       req,
	output line_wr_t   wr
);

	value_t              rem;
	logic [STEP_W-1:0]   step;
	value_t              pow;
	logic [3:0]          digit;
	logic [MULT_W-1:0]   sub;
	char_t               code;
	logic                shift_en;

	// digits are produced while busy and not yet waiting for the buffer.
	assign shift_en = busy && !req;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// digit selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the first step works on 10^9, the last on 10^0.
	assign pow = POW10[DIGITS - 1 - int'(step)];

	// every multiple from one to nine is compared at once; the largest that fits wins.
	always_comb begin : pick_digit
		logic [MULT_W-1:0] mult;

		mult  = '0;
		digit = '0;
		sub   = '0;
		for (int k = 1; k <= 9; k++) begin
			mult = MULT_W'(pow) * MULT_W'(k);
			if (MULT_W'(rem) >= mult) begin
				digit = 4'(k);
				sub   = mult;
			end
		end
	end

	assign code = CHAR_ZERO + char_t'(digit);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			req  <= 1'b0;
			step <= '0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end
		end else if (req) begin
			// the write lands on this edge, so the unit is free again.
			if (gnt) begin
				busy <= 1'b0;
				req  <= 1'b0;
			end
		end else begin
			step <= step + 1'b1;
			if (step == STEP_W'(DIGITS - 1)) begin
				req <= 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// remainder and word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			rem     <= value;
			wr.addr <= addr;
		end else if (shift_en) begin
			// sub never exceeds the remainder, so the low bits hold the whole difference.
			rem     <= rem - sub[VALUE_W-1:0];
			wr.word <= {wr.word[DIGITS-2:0], code};
		end
	end

endmodule

/* logic/oct_char_conv.sv */
// octal conversion unit; a start pulse turns a binary value into ten digit codes and a buffer write.
`timescale 1ns/100ps

module oct_char_conv import print_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  value_t     value,
	input  line_addr_t addr,
	input  logic       gnt,
	output logic       busy,
	output logic       req,
	output line_wr_t   wr
);

	value_t                sh;
	logic [STEP_W-1:0]     step;
	logic [OCT_BITS-1:0]   digit;
	char_t                 code;
	logic                  shift_en;

	assign shift_en = busy && !req;

	// the top three bits are the next digit, most significant first.
	assign digit = sh[VALUE_W-1 -: OCT_BITS];
	assign code  = CHAR_ZERO + char_t'(digit);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			req  <= 1'b0;
			step <= '0;
		end else if (!busy) begin
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end
		end else if (req) begin
			if (gnt) begin
				busy <= 1'b0;
				req  <= 1'b0;
			end
		end else begin
			step <= step + 1'b1;
			if (step == STEP_W'(DIGITS - 1)) begin
				req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			sh      <= value;
			wr.addr <= addr;
		end else if (shift_en) begin
			sh      <= sh << OCT_BITS;
			wr.word <= {wr.word[DIGITS-2:0], code};
		end
	end

endmodule

/* logic/line_arbiter.sv */
// round-robin arbiter that passes one converter write per cycle to the line buffer.
`timescale 1ns/100ps

module line_arbiter import print_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     dec_req,
	input  line_wr_t dec_wr,
	input  logic     oct_req,
	input  line_wr_t oct_wr,
	output logic     gnt_dec,
	output logic     gnt_oct,
	output logic     wr_en,
	output line_wr_t wr
);

	// high when the decimal unit took the last grant.
	logic last_dec;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// grant
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a lone requester always wins. On a conflict the unit that did not win last
	// goes first.
	assign gnt_dec = dec_req && (!oct_req || !last_dec);
	assign gnt_oct = oct_req && (!dec_req || last_dec);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_dec <= 1'b0;
		end else if (gnt_dec) begin
			last_dec <= 1'b1;
		end else if (gnt_oct) begin
			last_dec <= 1'b0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wr_en = gnt_dec || gnt_oct;

	// the payload follows the grant; without a grant wr_en keeps it out of the buffer.
	assign wr = gnt_oct ? oct_wr : dec_wr;

endmodule

/* logic/line_buffer.sv */
// sixteen-word character line memory; one write port from the arbiter, one registered read port.
`timescale 1ns/100ps

module line_buffer import print_pkg::*; (
	input  logic       clk,
	input  logic       wr_en,
	input  line_wr_t   wr,
	input  line_addr_t rd_addr,
	output char_word_t rd_data
);

	char_word_t mem [LINE_DEPTH];

	// the word is stored on the edge where the arbiter grants it.
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr.addr] <= wr.word;
		end
	end

	// read data shows up one cycle after the address.
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* logic/print_unit.sv */
// top level of the printing subsystem; wires both converters through the arbiter into the buffer.
`timescale 1ns/100ps

module print_unit import print_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       dec_start,
	input  value_t     dec_value,
	input  line_addr_t dec_addr,
	input  logic       oct_start,
	input  value_t     oct_value,
	input  line_addr_t oct_addr,
	output logic       dec_busy,
	output logic       oct_busy,
	input  line_addr_t rd_addr,
	output char_word_t rd_data
);

	logic     dec_req;
	logic     oct_req;
	logic     gnt_dec;
	logic     gnt_oct;
	line_wr_t dec_wr;
	line_wr_t oct_wr;
	logic     wr_en;
	line_wr_t buf_wr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// converters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	dec_char_conv dec_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (dec_start),
		.value (dec_value),
		.addr  (dec_addr),
		.gnt   (gnt_dec),
		.busy  (dec_busy),
		.req   (dec_req),
		.wr    (dec_wr)
	);

	oct_char_conv oct_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (oct_start),
		.value (oct_value),
		.addr  (oct_addr),
		.gnt   (gnt_oct),
		.busy  (oct_busy),
		.req   (oct_req),
		.wr    (oct_wr)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arbitration and storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	line_arbiter arb_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.dec_req (dec_req),
		.dec_wr  (dec_wr),
		.oct_req (oct_req),
		.oct_wr  (oct_wr),
		.gnt_dec (gnt_dec),
		.gnt_oct (gnt_oct),
		.wr_en   (wr_en),
		.wr      (buf_wr)
	);

	line_buffer buf_i (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr      (buf_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

/* sim/print_unit_assert.sv */
// concurrent checks on the line arbiter grants; the testbench binds this into line_arbiter.
`timescale 1ns/100ps

module print_unit_assert (
	input logic clk,
	input logic rst_n,
	input logic dec_req,
	input logic oct_req,
	input logic gnt_dec,
	input logic gnt_oct
);

	// the testbench reads this count when the run ends.
	int fail_count = 0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// grant rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		!(gnt_dec && gnt_oct))
	else begin
		$error("both grants high in the same cycle");
		fail_count++;
	end

	dec_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		gnt_dec |-> dec_req)
	else begin
		$error("decimal grant without a request");
		fail_count++;
	end

	oct_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		gnt_oct |-> oct_req)
	else begin
		$error("octal grant without a request");
		fail_count++;
	end

	// a lone request held for two cycles has to be served.
	dec_lone_served: assert property (@(posedge clk) disable iff (!rst_n)
		(dec_req && !oct_req) [*2] |-> gnt_dec)
	else begin
		$error("lone decimal request not granted");
		fail_count++;
	end

	oct_lone_served: assert property (@(posedge clk) disable iff (!rst_n)
		(oct_req && !dec_req) [*2] |-> gnt_oct)
	else begin
		$error("lone octal request not granted");
		fail_count++;
	end

endmodule

/* sim/print_unit_tb.sv */
// directed testbench for print_unit; run print_unit_tb as the top module with vlog.f.
`timescale 1ns/100ps

module print_unit_tb import print_pkg::*; ();

	localparam int          PERIOD_NS   = 20;
	localparam logic [15:0] SEED        = 16'd46045;
	localparam int          SWEEP_RUNS  = 20;
	localparam int          TEST_RUNS   = 32;
	localparam int          WATCHDOG_NS = (TEST_RUNS * 20 + 100) * PERIOD_NS;

	logic       clk;
	logic       rst_n;
	logic       dec_start;
	value_t     dec_value;
	line_addr_t dec_addr;
	logic       oct_start;
	value_t     oct_value;
	line_addr_t oct_addr;
	logic       dec_busy;
	logic       oct_busy;
	line_addr_t rd_addr;
	char_word_t rd_data;
	logic [15:0] lfsr_state;

	print_unit dut_i (.*);

	bind line_arbiter print_unit_assert arb_assert_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.dec_req (dec_req),
		.oct_req (oct_req),
		.gnt_dec (gnt_dec),
		.gnt_oct (gnt_oct)
	);

	always #(PERIOD_NS / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// model and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// digit d is code 30 + d, least significant digit in slot 0.
	function automatic char_word_t model_word(input value_t v, input int base);
		char_word_t w;
		longint unsigned rest;

		rest = v;
		for (int i = 0; i < DIGITS; i++) begin
			w[i] = char_t'(30 + rest % base);
			rest = rest / base;
		end
		return w;
	endfunction

	// the Galois register advances once for every bit handed out.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;

		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped on error");
	endtask

	task automatic check_word(input string name, input line_addr_t a,
			input char_word_t got, input char_word_t exp);
		assert (got === exp) else begin
			$display("FAIL %s[%0h]: got %h, expected %h", name, a, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// start is sampled on the edge at which this task returns.
	task automatic start_dec(input value_t v, input line_addr_t a);
		@(posedge clk);
		dec_start <= 1'b1;
		dec_value <= v;
		dec_addr  <= a;
		@(posedge clk);
		dec_start <= 1'b0;
	endtask

	task automatic start_oct(input value_t v, input line_addr_t a);
		@(posedge clk);
		oct_start <= 1'b1;
		oct_value <= v;
		oct_addr  <= a;
		@(posedge clk);
		oct_start <= 1'b0;
	endtask

	task automatic wait_idle(input int max_cycles);
		int n;

		n = 0;
		@(negedge clk);
		while ((dec_busy || oct_busy) && n < max_cycles) begin
			n++;
			@(negedge clk);
		end
		assert (!(dec_busy || oct_busy)) else begin
			$display("busy did not fall within %0d cycles of the start", max_cycles);
			abort_run();
		end
	endtask

	task automatic read_word(input line_addr_t a, output char_word_t w);
		@(posedge clk);
		rd_addr <= a;
		@(posedge clk);
		@(negedge clk);
		w = rd_data;
	endtask

	task automatic run_dec(input value_t v, input line_addr_t a);
		char_word_t got;

		start_dec(v, a);
		wait_idle(12);
		read_word(a, got);
		check_word("rd_data", a, got, model_word(v, 10));
	endtask

	task automatic run_oct(input value_t v, input line_addr_t a);
		char_word_t got;

		start_oct(v, a);
		wait_idle(12);
		read_word(a, got);
		check_word("rd_data", a, got, model_word(v, 8));
	endtask

	task automatic run_pair(input value_t dv, input line_addr_t da,
			input value_t ov, input line_addr_t oa);
		char_word_t got;

		fork
			start_dec(dv, da);
			start_oct(ov, oa);
		join
		wait_idle(12);
		read_word(da, got);
		check_word("rd_data", da, got, model_word(dv, 10));
		read_word(oa, got);
		check_word("rd_data", oa, got, model_word(ov, 8));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_idle();
		@(negedge clk);
		check_bit("dec_busy", dec_busy, 1'b0);
		check_bit("oct_busy", oct_busy, 1'b0);
	endtask

	task automatic test_dec_values();
		run_dec(30'd0, 4'd0);
		run_dec(30'd123456789, 4'd1);
		run_dec(30'd1073741823, 4'd2);
	endtask

	task automatic test_oct_values();
		run_oct(30'd0, 4'd3);
		run_oct(30'o7654321076, 4'd4);
		run_oct(30'h3fffffff, 4'd5);
	endtask

	task automatic test_both_start();
		run_pair(30'd987654321, 4'd8, 30'o1234567012, 4'd9);
	endtask

	// the second start falls in the middle of the first conversion.
	task automatic test_start_while_busy();
		char_word_t got;

		run_dec(30'd555, 4'd7);
		start_dec(30'd111, 4'd6);
		repeat (3) @(posedge clk);
		start_dec(30'd999, 4'd7);
		wait_idle(12);
		read_word(4'd6, got);
		check_word("rd_data", 4'd6, got, model_word(30'd111, 10));
		read_word(4'd7, got);
		check_word("rd_data", 4'd7, got, model_word(30'd555, 10));
	endtask

	task automatic test_random_sweep();
		value_t     dv;
		value_t     ov;
		line_addr_t da;
		line_addr_t oa;

		for (int i = 0; i < SWEEP_RUNS; i++) begin
			dv = value_t'(rand_bits(VALUE_W));
			ov = value_t'(rand_bits(VALUE_W));
			da = line_addr_t'(rand_bits(ADDR_W));
			// an offset of one to eight keeps the two addresses apart.
			oa = da ^ line_addr_t'(rand_bits(3) + 1);
			run_pair(dv, da, ov, oa);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		wait (dut_i.arb_i.arb_assert_i.fail_count != 0);
		$display("an arbiter assertion failed during the run");
		abort_run();
	end

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		dec_start  = 1'b0;
		dec_value  = '0;
		dec_addr   = '0;
		oct_start  = 1'b0;
		oct_value  = '0;
		oct_addr   = '0;
		rd_addr    = '0;
		lfsr_state = SEED;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_idle();
		test_dec_values();
		test_oct_values();
		test_both_start();
		test_start_while_busy();
		test_random_sweep();
		if (dut_i.arb_i.arb_assert_i.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("arbiter assertions failed %0d times",
				dut_i.arb_i.arb_assert_i.fail_count);
			abort_run();
		end
	end

endmodule

/* vlog.f */
logic/print_pkg.sv
logic/dec_char_conv.sv
logic/oct_char_conv.sv
logic/line_arbiter.sv
logic/line_buffer.sv
logic/print_unit.sv
sim/print_unit_assert.sv
sim/print_unit_tb.sv

/* Bender.yml */
package:
  name: print_unit

sources:
  - logic/print_pkg.sv
  - logic/dec_char_conv.sv
  - logic/oct_char_conv.sv
  - logic/line_arbiter.sv
  - logic/line_buffer.sv
  - logic/print_unit.sv
  - target: simulation
    files:
      - sim/print_unit_assert.sv
      - sim/print_unit_tb.sv
